// File: axi_shifter_ctrl.f
design/axi_shifter_pkg.sv
design/axi_write_slave.sv
design/shifter_command_decoder.sv
design/axi_read_responder.sv
design/axi_shifter_ctrl.sv
testbench/tb_clock_gen.sv
testbench/axi_shifter_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f axi_shifter_ctrl.f \
    --top-module axi_shifter_ctrl_tb \
    -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: testbench/axi_shifter_ctrl_tb.sv
`timescale 1ns/1ns

module axi_shifter_ctrl_tb;
    import axi_shifter_pkg::*;

    localparam int DELAY_WIDTH = 30;
    localparam int EVENT_WIDTH = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TRANS   = 80;
    localparam int SEED        = 77438;

    typedef logic [DELAY_WIDTH-1:0] delay_t;
    typedef logic [EVENT_WIDTH-1:0] event_t;

    // One expected shifter command
    typedef struct packed {
        cmd_kind_e    kind;
        cmd_payload_t value;
    } shift_cmd_t;

    logic       s_axi_aclk;
    logic       s_axi_aresetn;
    axi_addr_t  s_axi_awaddr;
    axi_id_t    s_axi_awid;
    logic       s_axi_awvalid;
    logic       s_axi_awready;
    axi_data_t  s_axi_wdata;
    axi_strb_t  s_axi_wstrb;
    logic       s_axi_wlast;
    logic       s_axi_wvalid;
    logic       s_axi_wready;
    logic       s_axi_bready;
    logic       s_axi_bvalid;
    axi_id_t    s_axi_bid;
    axi_resp_t  s_axi_bresp;
    axi_addr_t  s_axi_araddr;
    axi_id_t    s_axi_arid;
    logic       s_axi_arvalid;
    logic       s_axi_arready;
    logic       s_axi_rready;
    logic       s_axi_rvalid;
    logic       s_axi_rlast;
    axi_data_t  s_axi_rdata;
    axi_resp_t  s_axi_rresp;
    axi_id_t    s_axi_rid;
    delay_t     delay_value;
    logic       delay_set;
    event_t     event_value;
    logic       event_set;
    logic       event_polarity_set;

    // Model state, written by the driver
    shift_cmd_t exp_q[$];
    axi_id_t    exp_bid;
    axi_resp_t  exp_bresp;
    axi_id_t    exp_rid;
    int         writes_issued = 0;
    int         reads_issued  = 0;
    // Monitor progress, written by the monitor only
    int         cmds_seen   = 0;
    int         writes_done = 0;
    int         reads_done  = 0;

    tb_clock_gen #(.period_ns(CLK_PERIOD), .reset_cycles(10)) tb_clock_gen_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn)
    );

    axi_shifter_ctrl #(
        .delay_width (DELAY_WIDTH),
        .event_width (EVENT_WIDTH)
    ) axi_shifter_ctrl_inst (
        .s_axi_aclk(s_axi_aclk), .s_axi_aresetn(s_axi_aresetn),
        .s_axi_awaddr(s_axi_awaddr), .s_axi_awid(s_axi_awid),
        .s_axi_awvalid(s_axi_awvalid), .s_axi_awready(s_axi_awready),
        .s_axi_wdata(s_axi_wdata), .s_axi_wstrb(s_axi_wstrb), .s_axi_wlast(s_axi_wlast),
        .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
        .s_axi_bready(s_axi_bready), .s_axi_bvalid(s_axi_bvalid),
        .s_axi_bid(s_axi_bid), .s_axi_bresp(s_axi_bresp),
        .s_axi_araddr(s_axi_araddr), .s_axi_arid(s_axi_arid),
        .s_axi_arvalid(s_axi_arvalid), .s_axi_arready(s_axi_arready),
        .s_axi_rready(s_axi_rready), .s_axi_rvalid(s_axi_rvalid), .s_axi_rlast(s_axi_rlast),
        .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp), .s_axi_rid(s_axi_rid),
        .delay_value(delay_value), .delay_set(delay_set),
        .event_value(event_value), .event_set(event_set),
        .event_polarity_set(event_polarity_set)
    );

    ////////////////////////////////////////////////////////////
    // Failure handling and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_id(input string name, input axi_id_t exp, input axi_id_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_delay(input string name, input delay_t exp, input delay_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_event(input string name, input event_t exp, input event_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns %s expected %0b actual %0b", $time, name, exp, act);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic check_shifter();
        shift_cmd_t exp;
        int         strobes;
        strobes = int'(delay_set) + int'(event_set) + int'(event_polarity_set);
        if (strobes > 1) begin
            $display("More than one shifter command strobed in the same cycle");
            abort_run();
        end else if (strobes == 1) begin
            if (cmds_seen >= exp_q.size()) begin
                $display("Shifter command appeared while none was expected");
                abort_run();
            end
            exp = exp_q[cmds_seen];
            cmds_seen++;
            case (exp.kind)
                CMD_DELAY: begin
                    compare_bit("delay_set", 1'b1, delay_set);
                    compare_delay("delay_value", exp.value[DELAY_WIDTH-1:0], delay_value);
                end
                CMD_EVENT: begin
                    compare_bit("event_set", 1'b1, event_set);
                    compare_event("event_value", exp.value[EVENT_WIDTH-1:0], event_value);
                end
                default: begin
                    compare_bit("event_polarity_set", 1'b1, event_polarity_set);
                end
            endcase
        end
    endtask

    always @(negedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            // Commands first, a response may share the same edge
            check_shifter();
            if (s_axi_bvalid) begin
                if (writes_done >= writes_issued) begin
                    $display("Write response without an outstanding write");
                    abort_run();
                end
                if (cmds_seen != exp_q.size()) begin
                    $display("Write response arrived before all commands of its burst");
                    abort_run();
                end
                compare_id("s_axi_bid", exp_bid, s_axi_bid);
                compare_resp("s_axi_bresp", exp_bresp, s_axi_bresp);
                writes_done++;
            end
            if (s_axi_rvalid) begin
                if (reads_done >= reads_issued) begin
                    $display("Read data without an outstanding read");
                    abort_run();
                end
                compare_bit("s_axi_rlast", 1'b1, s_axi_rlast);
                compare_data("s_axi_rdata", '0, s_axi_rdata);
                compare_resp("s_axi_rresp", RESP_OKAY, s_axi_rresp);
                compare_id("s_axi_rid", exp_rid, s_axi_rid);
                reads_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Driver tasks, called on a rising edge
    ////////////////////////////////////////////////////////////

    function automatic axi_addr_t pick_bad_addr();
        axi_addr_t addr;
        do begin
            addr = axi_addr_t'($urandom());
        end while (addr == ADDR_DELAY || addr == ADDR_EVENT || addr == ADDR_POLARITY);
        return addr;
    endfunction

    task automatic write_burst(input axi_addr_t addr, input bit is_cmd, input cmd_kind_e kind);
        axi_id_t    id;
        axi_data_t  data;
        shift_cmd_t cmd;
        int         beats;
        int         gap;
        id        = axi_id_t'($urandom());
        beats     = is_cmd ? int'($urandom_range(1, 8)) : 0;
        exp_bid   = id;
        exp_bresp = is_cmd ? RESP_OKAY : RESP_SLVERR;
        writes_issued++;
        s_axi_awaddr  <= addr;
        s_axi_awid    <= id;
        s_axi_awvalid <= 1'b1;
        do @(negedge s_axi_aclk); while (!s_axi_awready);
        @(posedge s_axi_aclk);
        s_axi_awvalid <= 1'b0;
        // Rejected address keeps the data channel closed
        if (!is_cmd) begin
            @(negedge s_axi_aclk);
            compare_bit("s_axi_wready", 1'b0, s_axi_wready);
            @(posedge s_axi_aclk);
        end
        // Rejected address sends no beats at all
        for (int i = 0; i < beats; i++) begin
            gap = int'($urandom_range(0, 2));
            if (gap > 0) begin
                s_axi_wvalid <= 1'b0;
                repeat (gap) @(posedge s_axi_aclk);
            end
            data = {$urandom(), $urandom(), $urandom(), $urandom()};
            // Polarity beat with bit 0 clear leaves no pulse
            if (kind != CMD_POLARITY || data[0]) begin
                cmd.kind  = kind;
                cmd.value = data[31:0];
                exp_q.push_back(cmd);
            end
            s_axi_wdata  <= data;
            s_axi_wlast  <= (i == beats - 1);
            s_axi_wvalid <= 1'b1;
            do @(negedge s_axi_aclk); while (!s_axi_wready);
            @(posedge s_axi_aclk);
        end
        s_axi_wvalid <= 1'b0;
        s_axi_wlast  <= 1'b0;
        wait (writes_done == writes_issued);
        @(posedge s_axi_aclk);
    endtask

    task automatic read_single();
        axi_id_t id;
        id      = axi_id_t'($urandom());
        exp_rid = id;
        reads_issued++;
        s_axi_araddr  <= axi_addr_t'($urandom());
        s_axi_arid    <= id;
        s_axi_arvalid <= 1'b1;
        do @(negedge s_axi_aclk); while (!s_axi_arready);
        @(posedge s_axi_aclk);
        s_axi_arvalid <= 1'b0;
        wait (reads_done == reads_issued);
        @(posedge s_axi_aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        s_axi_awaddr  <= '0;
        s_axi_awid    <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '1;
        s_axi_wlast   <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        s_axi_araddr  <= '0;
        s_axi_arid    <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        wait (s_axi_aresetn);
        // Both address channels idle after reset
        @(negedge s_axi_aclk);
        compare_bit("s_axi_awready", 1'b1, s_axi_awready);
        compare_bit("s_axi_arready", 1'b1, s_axi_arready);
        @(posedge s_axi_aclk);
        for (int n = 0; n < NUM_TRANS; n++) begin
            case ($urandom_range(0, 4))
                0:       write_burst(ADDR_DELAY, 1'b1, CMD_DELAY);
                1:       write_burst(ADDR_EVENT, 1'b1, CMD_EVENT);
                2:       write_burst(ADDR_POLARITY, 1'b1, CMD_POLARITY);
                3:       write_burst(pick_bad_addr(), 1'b0, CMD_DELAY);
                default: read_single();
            endcase
        end
        repeat (4) @(posedge s_axi_aclk);
        if (cmds_seen != exp_q.size()) begin
            $display("Expected shifter commands never appeared: %0d missing",
                     exp_q.size() - cmds_seen);
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    // Generous bound per transaction
    initial begin
        #(NUM_TRANS * 40 * CLK_PERIOD);
        $display("Watchdog expired before all transactions completed");
        abort_run();
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 10
) (
    output logic s_axi_aclk,
    output logic s_axi_aresetn
);

    // Free-running clock
    initial begin
        s_axi_aclk = 1'b0;
        forever #(period_ns / 2) s_axi_aclk = ~s_axi_aclk;
    end

    // Reset low for the first cycles, released on a rising edge
    initial begin
        s_axi_aresetn <= 1'b0;
        repeat (reset_cycles) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;
    end

endmodule

// File: design/axi_shifter_ctrl.sv
`timescale 1ns/1ns

module axi_shifter_ctrl #(
    // 10^9 maximum delay
    parameter int delay_width = 30,
    // At most 10 events
    parameter int event_width = 4
) (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,
    // Write address channel
    input  axi_shifter_pkg::axi_addr_t s_axi_awaddr,
    input  axi_shifter_pkg::axi_id_t   s_axi_awid,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    // Write data channel, strobes are ignored
    input  axi_shifter_pkg::axi_data_t s_axi_wdata,
    input  axi_shifter_pkg::axi_strb_t s_axi_wstrb,
    input  logic                       s_axi_wlast,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    // Write response channel
    input  logic                       s_axi_bready,
    output logic                       s_axi_bvalid,
    output axi_shifter_pkg::axi_id_t   s_axi_bid,
    output axi_shifter_pkg::axi_resp_t s_axi_bresp,
    // Read address channel, address ends here
    input  axi_shifter_pkg::axi_addr_t s_axi_araddr,
    input  axi_shifter_pkg::axi_id_t   s_axi_arid,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    // Read data channel
    input  logic                       s_axi_rready,
    output logic                       s_axi_rvalid,
    output logic                       s_axi_rlast,
    output axi_shifter_pkg::axi_data_t s_axi_rdata,
    output axi_shifter_pkg::axi_resp_t s_axi_rresp,
    output axi_shifter_pkg::axi_id_t   s_axi_rid,
    // Shifter command port
    output logic [delay_width-1:0]     delay_value,
    output logic                       delay_set,
    output logic [event_width-1:0]     event_value,
    output logic                       event_set,
    output logic                       event_polarity_set
);
    import axi_shifter_pkg::*;

    // Producer to consumer strobe
    cmd_beat_t cmd_beat;

    ////////////////////////////////////////////////////////////
    // Write path
    ////////////////////////////////////////////////////////////

    axi_write_slave axi_write_slave_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awid    (s_axi_awid),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wlast   (s_axi_wlast),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bid     (s_axi_bid),
        .s_axi_bresp   (s_axi_bresp),
        .cmd_beat      (cmd_beat)
    );

    // Widths set here reach the shifter outputs
    shifter_command_decoder #(
        .delay_width (delay_width),
        .event_width (event_width)
    ) shifter_command_decoder_inst (
        .s_axi_aclk         (s_axi_aclk),
        .s_axi_aresetn      (s_axi_aresetn),
        .cmd_beat           (cmd_beat),
        .delay_value        (delay_value),
        .delay_set          (delay_set),
        .event_value        (event_value),
        .event_set          (event_set),
        .event_polarity_set (event_polarity_set)
    );

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    axi_read_responder axi_read_responder_inst (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_arid    (s_axi_arid),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rid     (s_axi_rid)
    );

endmodule

// File: design/axi_read_responder.sv
`timescale 1ns/1ns

module axi_read_responder (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,
    // Read address channel, address itself not decoded
    input  axi_shifter_pkg::axi_id_t   s_axi_arid,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    // Read data channel
    input  logic                       s_axi_rready,
    output logic                       s_axi_rvalid,
    output logic                       s_axi_rlast,
    output axi_shifter_pkg::axi_data_t s_axi_rdata,
    output axi_shifter_pkg::axi_resp_t s_axi_rresp,
    output axi_shifter_pkg::axi_id_t   s_axi_rid
);
    import axi_shifter_pkg::*;

    rd_state_e rd_state;
    axi_id_t   rd_id;
    logic      ar_fire;
    logic      r_fire;

    assign s_axi_arready = (rd_state == RD_IDLE);
    assign ar_fire       = s_axi_arvalid && s_axi_arready;
    // Beat goes out once the master holds rready
    assign r_fire        = (rd_state == RD_DATA) && s_axi_rready;

    // No readable registers, every beat is zero
    assign s_axi_rdata   = '0;
    assign s_axi_rresp   = RESP_OKAY;

    ////////////////////////////////////////////////////////////
    // Read FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_state     <= RD_IDLE;
            s_axi_rvalid <= 1'b0;
            s_axi_rlast  <= 1'b0;
        end else begin
            s_axi_rvalid <= 1'b0;
            s_axi_rlast  <= 1'b0;
            case (rd_state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    // Single beat, so it is also the last
                    if (r_fire) begin
                        s_axi_rvalid <= 1'b1;
                        s_axi_rlast  <= 1'b1;
                        rd_state     <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // ID kept until its beat is delivered
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            rd_id <= s_axi_arid;
        end
        if (r_fire) begin
            s_axi_rid <= rd_id;
        end
    end

    // Every read beat closes its burst
    rvalid_has_rlast: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid |-> s_axi_rlast);

endmodule

// File: design/shifter_command_decoder.sv
`timescale 1ns/1ns

module shifter_command_decoder #(
    parameter int delay_width = 30,
    parameter int event_width = 4
) (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,
    // Beat from the write slave, no back-pressure
    input  axi_shifter_pkg::cmd_beat_t cmd_beat,
    // Shifter command port
    output logic [delay_width-1:0]     delay_value,
    output logic                       delay_set,
    output logic [event_width-1:0]     event_value,
    output logic                       event_set,
    output logic                       event_polarity_set
);
    import axi_shifter_pkg::*;

    ////////////////////////////////////////////////////////////
    // Command register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            delay_value        <= '0;
            delay_set          <= 1'b0;
            event_value        <= '0;
            event_set          <= 1'b0;
            event_polarity_set <= 1'b0;
        end else begin
            // Idle unless a beat arrives this cycle
            delay_value        <= '0;
            delay_set          <= 1'b0;
            event_value        <= '0;
            event_set          <= 1'b0;
            event_polarity_set <= 1'b0;
            if (cmd_beat.valid) begin
                case (cmd_beat.kind)
                    CMD_DELAY: begin
                        // Truncated to the shifter delay range
                        delay_value <= delay_width'(cmd_beat.payload);
                        delay_set   <= 1'b1;
                    end
                    CMD_EVENT: begin
                        event_value <= event_width'(cmd_beat.payload);
                        event_set   <= 1'b1;
                    end
                    CMD_POLARITY: begin
                        // Level taken straight from bit 0
                        event_polarity_set <= cmd_beat.payload[0];
                    end
                    default: begin
                        // Unused encoding, outputs stay idle
                        event_polarity_set <= 1'b0;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Delay and event commands never collide
    strobes_exclusive: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $onehot0({delay_set, event_set}));

endmodule

// File: design/axi_write_slave.sv
`timescale 1ns/1ns

module axi_write_slave (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,
    // Write address channel
    input  axi_shifter_pkg::axi_addr_t s_axi_awaddr,
    input  axi_shifter_pkg::axi_id_t   s_axi_awid,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    // Write data channel
    input  axi_shifter_pkg::axi_data_t s_axi_wdata,
    input  logic                       s_axi_wlast,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    // Write response channel
    input  logic                       s_axi_bready,
    output logic                       s_axi_bvalid,
    output axi_shifter_pkg::axi_id_t   s_axi_bid,
    output axi_shifter_pkg::axi_resp_t s_axi_bresp,
    // Command beat towards the decoder
    output axi_shifter_pkg::cmd_beat_t cmd_beat
);
    import axi_shifter_pkg::*;

    wr_state_e    wr_state;
    // Burst context, held from AW handshake to response
    axi_id_t      wr_id;
    cmd_kind_e    wr_kind;
    // Address decode of the incoming AW request
    cmd_kind_e    aw_kind;
    logic         aw_is_cmd;
    // Handshakes
    logic         aw_fire;
    logic         w_fire;
    logic         b_fire;
    // Registered beat
    logic         beat_valid;
    cmd_payload_t beat_payload;

    ////////////////////////////////////////////////////////////
    // Handshakes and ready signals
    ////////////////////////////////////////////////////////////

    // Address accepted only when idle
    assign s_axi_awready = (wr_state == WR_IDLE);
    // Data accepted only for a decoded command burst
    assign s_axi_wready  = (wr_state == WR_DATA);

    assign aw_fire = s_axi_awvalid && s_axi_awready;
    assign w_fire  = s_axi_wvalid && s_axi_wready;
    // Response goes out once the master holds bready
    assign b_fire  = ((wr_state == WR_RESPONSE) || (wr_state == WR_ERROR)) && s_axi_bready;

    // Command address decode
    always_comb begin
        aw_kind   = CMD_DELAY;
        aw_is_cmd = 1'b1;
        case (s_axi_awaddr)
            ADDR_DELAY:    aw_kind = CMD_DELAY;
            ADDR_EVENT:    aw_kind = CMD_EVENT;
            ADDR_POLARITY: aw_kind = CMD_POLARITY;
            // Anything else ends in SLVERR
            default:       aw_is_cmd = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            wr_state     <= WR_IDLE;
            s_axi_bvalid <= 1'b0;
            beat_valid   <= 1'b0;
        end else begin
            // One-cycle strobes by default
            s_axi_bvalid <= 1'b0;
            beat_valid   <= w_fire;
            case (wr_state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        // Rejected address skips the data phase
                        wr_state <= aw_is_cmd ? WR_DATA : WR_ERROR;
                    end
                end
                WR_DATA: begin
                    if (w_fire && s_axi_wlast) begin
                        wr_state <= WR_RESPONSE;
                    end
                end
                WR_RESPONSE, WR_ERROR: begin
                    if (b_fire) begin
                        s_axi_bvalid <= 1'b1;
                        wr_state     <= WR_IDLE;
                    end
                end
                default: begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // Burst context and beat data
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            wr_id   <= s_axi_awid;
            wr_kind <= aw_kind;
        end
        if (w_fire) begin
            beat_payload <= s_axi_wdata[CMD_PAYLOAD_WIDTH-1:0];
        end
        if (b_fire) begin
            s_axi_bid   <= wr_id;
            s_axi_bresp <= (wr_state == WR_ERROR) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // Kind stays stable until the next AW, long after the last beat
    assign cmd_beat = '{valid: beat_valid, kind: wr_kind, payload: beat_payload};

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Response is a single pulse even with bready held high
    bvalid_single_cycle: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid |=> !s_axi_bvalid);

    // Beats land only while a command burst is open or awaiting its response
    beat_within_burst: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        cmd_beat.valid |-> ((wr_state == WR_DATA) || (wr_state == WR_RESPONSE)));

endmodule

// File: design/axi_shifter_pkg.sv
package axi_shifter_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    localparam int AXI_ADDR_WIDTH    = 6;
    localparam int AXI_DATA_WIDTH    = 128;
    localparam int AXI_STRB_WIDTH    = AXI_DATA_WIDTH / 8;
    localparam int AXI_ID_WIDTH      = 16;
    localparam int AXI_RESP_WIDTH    = 2;
    // Only the low word of a beat reaches the shifter
    localparam int CMD_PAYLOAD_WIDTH = 32;

    typedef logic [AXI_ADDR_WIDTH-1:0]    axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]    axi_data_t;
    typedef logic [AXI_STRB_WIDTH-1:0]    axi_strb_t;
    typedef logic [AXI_ID_WIDTH-1:0]      axi_id_t;
    typedef logic [AXI_RESP_WIDTH-1:0]    axi_resp_t;
    typedef logic [CMD_PAYLOAD_WIDTH-1:0] cmd_payload_t;

    // AXI response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    localparam axi_addr_t ADDR_DELAY    = 6'h10;
    localparam axi_addr_t ADDR_EVENT    = 6'h20;
    localparam axi_addr_t ADDR_POLARITY = 6'h30;

    // Target of one write burst
    typedef enum logic [1:0] {
        CMD_DELAY,
        CMD_EVENT,
        CMD_POLARITY
    } cmd_kind_e;

    // One accepted data beat, valid for a single cycle
    typedef struct packed {
        logic         valid;
        cmd_kind_e    kind;
        cmd_payload_t payload;
    } cmd_beat_t;

    ////////////////////////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESPONSE,
        WR_ERROR
    } wr_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

endpackage
